// ==== design/lar_pkg.sv ====
// Look-ahead router shared definitions
// Direction encoding, mesh coordinate and flit layout, port count
// and input buffer depth used across the router.

package lar_pkg;

  // Router ports are four neighbours plus the local port
  localparam int unsigned NumRoutes = 5;

  // Each coordinate covers meshes up to 8 by 8
  localparam int unsigned CoordWidth = 3;

  localparam int unsigned PayloadWidth = 16;

  // Entries per input FIFO
  localparam int unsigned FifoDepth = 2;

  // Output direction that doubles as port index
  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Eject = 3'd4
  } route_direction_e;

  // Router position or packet destination
  typedef struct packed {
    logic [CoordWidth-1:0] x;
    logic [CoordWidth-1:0] y;
  } xy_id_t;

  // Single-flit packet
  // lookahead holds the output to take at the router receiving the flit
  typedef struct packed {
    xy_id_t                  dst_id;
    route_direction_e        lookahead;
    logic [PayloadWidth-1:0] payload;
  } flit_t;

endpackage

// ==== design/lar_route_select.sv ====
// XY route selection
// Picks the output direction at a given router position for a
// destination, resolving X before Y.

`timescale 1ns/1ps

module lar_route_select (
  input  lar_pkg::xy_id_t           cur_id_i,
  input  lar_pkg::xy_id_t           dst_id_i,
  output lar_pkg::route_direction_e route_o
);
  import lar_pkg::*;

  logic x_greater;
  logic x_smaller;
  logic y_greater;
  logic y_smaller;

  // Coordinate comparisons
  assign x_greater = dst_id_i.x > cur_id_i.x;
  assign x_smaller = dst_id_i.x < cur_id_i.x;
  assign y_greater = dst_id_i.y > cur_id_i.y;
  assign y_smaller = dst_id_i.y < cur_id_i.y;

  // X dimension first, then Y, eject when both match
  always_comb begin
    if (x_greater) begin
      route_o = East;
    end else if (x_smaller) begin
      route_o = West;
    end else if (y_greater) begin
      route_o = North;
    end else if (y_smaller) begin
      route_o = South;
    end else begin
      route_o = Eject;
    end
  end

endmodule

// ==== design/lar_look_ahead_routing.sv ====
// Look-ahead route computation
// Steps the current position one hop along the flit's lookahead and
// rewrites the lookahead with the XY direction at that next router.

`timescale 1ns/1ps

module lar_look_ahead_routing (
  input  lar_pkg::xy_id_t xy_id_i,
  input  lar_pkg::flit_t  flit_i,
  output lar_pkg::flit_t  flit_o
);
  import lar_pkg::*;

  xy_id_t           next_id;
  route_direction_e next_route;

  // Position of the neighbour the flit is heading to
  always_comb begin
    next_id = xy_id_i;
    case (flit_i.lookahead)
      North:   next_id.y = xy_id_i.y + 1'b1;
      South:   next_id.y = xy_id_i.y - 1'b1;
      East:    next_id.x = xy_id_i.x + 1'b1;
      West:    next_id.x = xy_id_i.x - 1'b1;
      default: next_id = xy_id_i;
    endcase
  end

  lar_route_select i_route_select (
    .cur_id_i ( next_id        ),
    .dst_id_i ( flit_i.dst_id  ),
    .route_o  ( next_route     )
  );

  // Only the lookahead field changes
  always_comb begin
    flit_o           = flit_i;
    flit_o.lookahead = next_route;
  end

endmodule

// ==== design/lar_input_port.sv ====
// Router input buffer
// Small circular FIFO per input that presents the head flit and the
// output it requests to the switch allocator.

`timescale 1ns/1ps

module lar_input_port (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      in_valid_i,
  input  lar_pkg::flit_t            in_flit_i,
  output logic                      in_ready_o,
  output logic                      head_valid_o,
  output lar_pkg::flit_t            head_flit_o,
  output lar_pkg::route_direction_e head_route_o,
  input  logic                      head_pop_i
);
  import lar_pkg::*;

  typedef logic [$clog2(FifoDepth)-1:0]   ptr_t;
  typedef logic [$clog2(FifoDepth+1)-1:0] count_t;

  flit_t  mem [FifoDepth];
  ptr_t   wr_ptr;
  ptr_t   rd_ptr;
  count_t count;
  logic   push;
  logic   pop;

  assign in_ready_o   = count != count_t'(FifoDepth);
  assign head_valid_o = count != '0;
  assign head_flit_o  = mem[rd_ptr];
  // Route already decided upstream
  assign head_route_o = head_flit_o.lookahead;

  assign push = in_valid_i && in_ready_o;
  assign pop  = head_pop_i && head_valid_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_t'(FifoDepth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_t'(FifoDepth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= in_flit_i;
    end
  end

  // Allocator never pops an empty buffer
  assert property (@(posedge clk_i) disable iff (reset_i)
    head_pop_i |-> head_valid_o);

  // Waiting head flit holds until it is taken
  assert property (@(posedge clk_i) disable iff (reset_i)
    head_valid_o && !head_pop_i |=> head_valid_o && $stable(head_flit_o));

endmodule

// ==== design/lar_switch_alloc.sv ====
// Switch allocator and crossbar
// Round-robin arbitration per output, crossbar from the rewritten flits
// and a registered output stage with valid/ready back-pressure.

`timescale 1ns/1ps

module lar_switch_alloc (
  input  logic                                                clk_i,
  input  logic                                                reset_i,
  input  logic                      [lar_pkg::NumRoutes-1:0] head_valid_i,
  input  lar_pkg::route_direction_e [lar_pkg::NumRoutes-1:0] head_route_i,
  input  lar_pkg::flit_t            [lar_pkg::NumRoutes-1:0] head_flit_i,
  output logic                      [lar_pkg::NumRoutes-1:0] head_pop_o,
  output logic                      [lar_pkg::NumRoutes-1:0] out_valid_o,
  output lar_pkg::flit_t            [lar_pkg::NumRoutes-1:0] out_flit_o,
  input  logic                      [lar_pkg::NumRoutes-1:0] out_ready_i
);
  import lar_pkg::*;

  // Indexed [output][input]
  logic [NumRoutes-1:0][NumRoutes-1:0] req;
  logic [NumRoutes-1:0][NumRoutes-1:0] grant;
  // Indexed [input][output]
  logic [NumRoutes-1:0][NumRoutes-1:0] grant_by_in;

  route_direction_e [NumRoutes-1:0] rr_ptr;
  route_direction_e [NumRoutes-1:0] win_idx;
  logic             [NumRoutes-1:0] out_free;
  logic             [NumRoutes-1:0] out_valid_q;
  flit_t            [NumRoutes-1:0] out_flit_q;

  for (genvar o = 0; o < NumRoutes; o++) begin : gen_req
    for (genvar i = 0; i < NumRoutes; i++) begin : gen_in
      assign req[o][i] = head_valid_i[i] && (head_route_i[i] == route_direction_e'(o));
      assign grant_by_in[i][o] = grant[o][i];
    end
  end

  for (genvar i = 0; i < NumRoutes; i++) begin : gen_pop
    assign head_pop_o[i] = |grant_by_in[i];
  end

  // Register can refill in the cycle it drains
  assign out_free = ~out_valid_q | out_ready_i;

  // First requester from the pointer onward wins
  always_comb begin
    int idx;
    grant = '0;
    for (int o = 0; o < NumRoutes; o++) begin
      win_idx[o] = North;
      for (int k = 0; k < NumRoutes; k++) begin
        idx = int'(rr_ptr[o]) + k;
        if (idx >= NumRoutes) begin
          idx = idx - NumRoutes;
        end
        if (out_free[o] && req[o][idx] && (grant[o] == '0)) begin
          grant[o][idx] = 1'b1;
          win_idx[o]    = route_direction_e'(idx[2:0]);
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_valid_q <= '0;
      for (int o = 0; o < NumRoutes; o++) begin
        rr_ptr[o] <= North;
      end
    end else begin
      for (int o = 0; o < NumRoutes; o++) begin
        if (out_free[o]) begin
          out_valid_q[o] <= |grant[o];
        end
        // Winner drops to lowest priority
        if (|grant[o]) begin
          rr_ptr[o] <= (win_idx[o] == Eject) ? North
                                             : route_direction_e'(win_idx[o] + 3'd1);
        end
      end
    end
  end

  // Crossbar into output registers
  always_ff @(posedge clk_i) begin
    for (int o = 0; o < NumRoutes; o++) begin
      if (|grant[o]) begin
        out_flit_q[o] <= head_flit_i[win_idx[o]];
      end
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_flit_o  = out_flit_q;

  for (genvar n = 0; n < NumRoutes; n++) begin : gen_chk
    // An input flit goes to one output only
    assert property (@(posedge clk_i) disable iff (reset_i)
      $onehot0(grant_by_in[n]));
    // An output takes at most one flit per cycle
    assert property (@(posedge clk_i) disable iff (reset_i)
      $onehot0(grant[n]));
  end

endmodule

// ==== design/lar_router.sv ====
// Look-ahead mesh router
// Five-port XY router with input FIFOs, per-input look-ahead rewrite of
// the header and a shared switch allocator with registered outputs.

`timescale 1ns/1ps

module lar_router (
  input  logic                                     clk_i,
  input  logic                                     reset_i,
  input  lar_pkg::xy_id_t                          xy_id_i,
  input  logic           [lar_pkg::NumRoutes-1:0] in_valid_i,
  input  lar_pkg::flit_t [lar_pkg::NumRoutes-1:0] in_flit_i,
  output logic           [lar_pkg::NumRoutes-1:0] in_ready_o,
  output logic           [lar_pkg::NumRoutes-1:0] out_valid_o,
  output lar_pkg::flit_t [lar_pkg::NumRoutes-1:0] out_flit_o,
  input  logic           [lar_pkg::NumRoutes-1:0] out_ready_i
);
  import lar_pkg::*;

  logic             [NumRoutes-1:0] head_valid;
  flit_t            [NumRoutes-1:0] head_flit;
  route_direction_e [NumRoutes-1:0] head_route;
  logic             [NumRoutes-1:0] head_pop;
  // Flits with lookahead for the next hop
  flit_t            [NumRoutes-1:0] la_flit;

  for (genvar p = 0; p < NumRoutes; p++) begin : gen_port
    lar_input_port i_input_port (
      .clk_i        ( clk_i          ),
      .reset_i      ( reset_i        ),
      .in_valid_i   ( in_valid_i[p]  ),
      .in_flit_i    ( in_flit_i[p]   ),
      .in_ready_o   ( in_ready_o[p]  ),
      .head_valid_o ( head_valid[p]  ),
      .head_flit_o  ( head_flit[p]   ),
      .head_route_o ( head_route[p]  ),
      .head_pop_i   ( head_pop[p]    )
    );

    lar_look_ahead_routing i_look_ahead (
      .xy_id_i ( xy_id_i      ),
      .flit_i  ( head_flit[p] ),
      .flit_o  ( la_flit[p]   )
    );
  end

  lar_switch_alloc i_switch_alloc (
    .clk_i        ( clk_i       ),
    .reset_i      ( reset_i     ),
    .head_valid_i ( head_valid  ),
    .head_route_i ( head_route  ),
    .head_flit_i  ( la_flit     ),
    .head_pop_o   ( head_pop    ),
    .out_valid_o  ( out_valid_o ),
    .out_flit_o   ( out_flit_o  ),
    .out_ready_i  ( out_ready_i )
  );

endmodule

// ==== tb/tb_lar_router.sv ====
// Testbench for the look-ahead mesh router
// Router sits at (3,3) and its XY traffic is checked against a reference
// route model with one scoreboard queue per input/output pair.

`timescale 1ns/1ps

module tb_lar_router;
  import lar_pkg::*;

  localparam int FlitsPerTest = 300;
  // Two random tests plus the single and directed flits
  localparam int TotalFlits = 2 * FlitsPerTest + 11;
  localparam int TimeoutCycles = 60 * TotalFlits + 200;
  localparam logic [31:0] LfsrSeed = 32'h55b2c685;
  localparam logic [31:0] LfsrTaps = 32'h80200003;
  localparam xy_id_t RouterId = xy_id_t'({3'd3, 3'd3});

  logic                  clk;
  logic                  reset;
  logic [NumRoutes-1:0]  in_valid;
  flit_t [NumRoutes-1:0] in_flit;
  logic [NumRoutes-1:0]  in_ready;
  logic [NumRoutes-1:0]  out_valid;
  flit_t [NumRoutes-1:0] out_flit;
  logic [NumRoutes-1:0]  out_ready;

  logic [31:0]          lfsr_state = LfsrSeed;
  logic [NumRoutes-1:0] in_fire;
  logic [NumRoutes-1:0] held;
  flit_t                held_flit [NumRoutes];
  flit_t                send_q [NumRoutes][$];
  // Expected flits indexed [input][output]
  flit_t                exp_q [NumRoutes][NumRoutes][$];
  logic [12:0]          seq [NumRoutes];
  logic                 stall_outputs;
  logic                 saw_full;
  int                   errors = 0;
  int                   checks = 0;
  int                   cycles = 0;
  string                test_name;

  lar_router uut (
    .clk_i       ( clk       ),
    .reset_i     ( reset     ),
    .xy_id_i     ( RouterId  ),
    .in_valid_i  ( in_valid  ),
    .in_flit_i   ( in_flit   ),
    .in_ready_o  ( in_ready  ),
    .out_valid_o ( out_valid ),
    .out_flit_o  ( out_flit  ),
    .out_ready_i ( out_ready )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ LfsrTaps : lfsr_state >> 1;
    end
    return v;
  endfunction

  // Reference XY rule with the X offset resolved first
  function automatic route_direction_e xy_route(input xy_id_t cur, input xy_id_t dst);
    int dx;
    int dy;
    dx = int'(dst.x) - int'(cur.x);
    dy = int'(dst.y) - int'(cur.y);
    if (dx != 0) begin
      return (dx > 0) ? East : West;
    end
    if (dy != 0) begin
      return (dy > 0) ? North : South;
    end
    return Eject;
  endfunction

  function automatic flit_t expected_out(input flit_t f);
    xy_id_t nxt;
    flit_t  e;
    nxt = RouterId;
    case (f.lookahead)
      North:   nxt.y = RouterId.y + 3'd1;
      South:   nxt.y = RouterId.y - 3'd1;
      East:    nxt.x = RouterId.x + 3'd1;
      West:    nxt.x = RouterId.x - 3'd1;
      default: nxt = RouterId;
    endcase
    e = f;
    e.lookahead = xy_route(nxt, f.dst_id);
    return e;
  endfunction

  function automatic route_direction_e random_port();
    logic [31:0] r;
    do begin
      r = rand_bits(3);
    end while (r >= NumRoutes);
    return route_direction_e'(r[2:0]);
  endfunction

  function automatic logic traffic_done();
    logic done;
    done = 1'b1;
    for (int p = 0; p < NumRoutes; p++) begin
      done &= (send_q[p].size() == 0) && !in_valid[p];
      for (int o = 0; o < NumRoutes; o++) begin
        done &= exp_q[p][o].size() == 0;
      end
    end
    return done;
  endfunction

  // Payload carries the source port and a per-port sequence number
  task automatic queue_flit(input route_direction_e port, input xy_id_t dst);
    flit_t f;
    f.dst_id    = dst;
    f.lookahead = xy_route(RouterId, dst);
    f.payload   = {port, seq[port]};
    seq[port]   = seq[port] + 13'd1;
    send_q[port].push_back(f);
  endtask

  // A neighbour never sends a flit straight back where it came from
  task automatic queue_random(input route_direction_e port);
    logic [31:0] r;
    do begin
      r = rand_bits(2 * CoordWidth);
    end while (xy_route(RouterId, xy_id_t'(r[2*CoordWidth-1:0])) == port);
    queue_flit(port, xy_id_t'(r[2*CoordWidth-1:0]));
  endtask

  task automatic drive_cycle();
    logic [31:0] r;
    @(negedge clk);
    for (int p = 0; p < NumRoutes; p++) begin
      if (in_fire[p]) begin
        in_valid[p] = 1'b0;
      end
      if (!in_valid[p] && send_q[p].size() > 0) begin
        in_flit[p]  = send_q[p].pop_front();
        in_valid[p] = 1'b1;
      end
      if (stall_outputs) begin
        r = rand_bits(1);
        out_ready[p] = r[0];
      end else begin
        out_ready[p] = 1'b1;
      end
    end
  endtask

  task automatic run_traffic(input string name);
    test_name = name;
    do begin
      drive_cycle();
    end while (!traffic_done());
    // Quiet cycles expose duplicated flits
    repeat (10) drive_cycle();
  endtask

  task automatic check_output(input int o, input flit_t got);
    int    src;
    logic  known;
    flit_t want;
    src   = int'(got.payload[PayloadWidth-1 -: 3]);
    known = 1'b0;
    if (src < NumRoutes) begin
      known = exp_q[src][o].size() > 0;
    end
    checks++;
    assert (known) else begin
      errors++;
      $display("Unexpected flit %h left output %0d in test %s", got, o, test_name);
    end
    if (known) begin
      want = exp_q[src][o].pop_front();
      checks++;
      assert (got == want) else begin
        errors++;
        $display("error %s: output %0d expected %h actual %h", test_name, o, want, got);
      end
    end
  endtask

  // Scoreboard sampling the values present before each rising edge
  always @(posedge clk) begin
    if (reset) begin
      in_fire = '0;
      held    = '0;
    end else begin
      for (int p = 0; p < NumRoutes; p++) begin
        in_fire[p] = in_valid[p] && in_ready[p];
        if (in_fire[p]) begin
          exp_q[p][in_flit[p].lookahead].push_back(expected_out(in_flit[p]));
        end
        saw_full |= !in_ready[p];
      end
      for (int o = 0; o < NumRoutes; o++) begin
        if (held[o]) begin
          checks++;
          assert (out_valid[o] && out_flit[o] == held_flit[o]) else begin
            errors++;
            $display("error %s: stalled output %0d expected %h actual %h",
                     test_name, o, held_flit[o], out_flit[o]);
          end
        end
        held[o]      = out_valid[o] && !out_ready[o];
        held_flit[o] = out_flit[o];
        if (out_valid[o] && out_ready[o]) begin
          check_output(o, out_flit[o]);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout after %0d cycles with flits still in flight", cycles);
      $display("Checks: %0d, errors: %0d", checks, errors + 1);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    reset         = 1'b1;
    in_valid      = '0;
    in_flit       = '0;
    out_ready     = '1;
    stall_outputs = 1'b0;
    saw_full      = 1'b0;
    for (int p = 0; p < NumRoutes; p++) begin
      seq[p] = '0;
    end
    repeat (10) @(negedge clk);
    reset = 1'b0;

    test_name = "reset";
    checks++;
    assert (out_valid == '0 && in_ready == '1) else begin
      errors++;
      $display("error %s: expected out_valid 00000 in_ready 11111 actual %b %b",
               test_name, out_valid, in_ready);
    end

    for (int p = 0; p < NumRoutes; p++) begin
      queue_random(route_direction_e'(p));
      run_traffic("single");
    end

    // Destinations given as {x, y}
    queue_flit(West, xy_id_t'({3'd6, 3'd3}));
    queue_flit(West, xy_id_t'({3'd4, 3'd6}));
    queue_flit(East, xy_id_t'({3'd2, 3'd0}));
    queue_flit(North, xy_id_t'({3'd3, 3'd0}));
    queue_flit(South, RouterId);
    queue_flit(Eject, xy_id_t'({3'd3, 3'd7}));
    run_traffic("directed");

    for (int n = 0; n < FlitsPerTest; n++) begin
      queue_random(random_port());
    end
    run_traffic("random");

    stall_outputs = 1'b1;
    saw_full      = 1'b0;
    for (int n = 0; n < FlitsPerTest; n++) begin
      queue_random(random_port());
    end
    run_traffic("backpressure");
    checks++;
    assert (saw_full) else begin
      errors++;
      $display("No input buffer filled up while the outputs were stalled");
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
design/lar_pkg.sv
design/lar_route_select.sv
design/lar_look_ahead_routing.sv
design/lar_input_port.sv
design/lar_switch_alloc.sv
design/lar_router.sv
tb/tb_lar_router.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_lar_router
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
